/* design/io_pkg.sv */
// shared widths, pad source encoding, register structs and address map for the io subsystem
`default_nettype none

package io_pkg;

  // largest pad count the register map has room for
  localparam int unsigned IO_MAX_PADS = 32;

  // owner of a pad, drives its out/oe and receives its input
  typedef enum logic [1:0] {
    PAD_SRC_GPIO   = 2'd0,
    PAD_SRC_PERIO  = 2'd1,
    PAD_SRC_FPGAIO = 2'd2,
    PAD_SRC_OFF    = 2'd3
  } pad_src_e;

  // pad cell configuration word
  typedef logic [5:0] pad_cfg_t;

  // one pad table entry, cfg in the upper bits and source in the low two
  typedef struct packed {
    pad_cfg_t cfg;
    pad_src_e src;
  } pad_entry_t;

  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // single register access, plain strobe without handshake
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  // address map
  // pad n lives at PAD_ENTRY_BASE + n
  localparam reg_addr_t PAD_ENTRY_BASE = 8'h00;
  localparam reg_addr_t GPIO_OUT_ADDR  = 8'h20;
  localparam reg_addr_t GPIO_OE_ADDR   = 8'h21;
  // read only, returns the synchronized pad inputs
  localparam reg_addr_t GPIO_IN_ADDR   = 8'h22;

endpackage

`default_nettype wire

/* design/io_regs.sv */
// register block holding the pad entry table and gpio registers, with registered readback
`timescale 1ns/1ps
`default_nettype none

module io_regs #(
  parameter int unsigned N_IO = 16
) (
  input  wire                                ref_clk_i,
  input  wire                                rst_i,
  // register access
  input  io_pkg::reg_req_t                   reg_req_i,
  output io_pkg::reg_data_t                  reg_rdata_o,
  // pad table towards the multiplexer
  output io_pkg::pad_entry_t [N_IO-1:0]      pad_entry_o,
  // gpio registers
  output logic               [N_IO-1:0]      gpio_out_o,
  output logic               [N_IO-1:0]      gpio_oe_o,
  input  wire                [N_IO-1:0]      gpio_in_i
);

  import io_pkg::*;

  localparam int unsigned EntryW = $bits(pad_entry_t);

  // every pad parked and unconfigured after reset
  localparam pad_entry_t EntryRst = '{cfg: '0, src: PAD_SRC_OFF};

  pad_entry_t [N_IO-1:0] entry_q;
  logic       [N_IO-1:0] gpio_out_q;
  logic       [N_IO-1:0] gpio_oe_q;

  // address decode
  reg_addr_t             entry_off;
  logic       [N_IO-1:0] entry_sel;
  logic                  gpio_out_sel;
  logic                  gpio_oe_sel;
  logic                  gpio_in_sel;

  reg_data_t             rdata_d;

  // one decode shared by the write and readback paths
  always_comb begin
    entry_off = reg_req_i.addr - PAD_ENTRY_BASE;
    for (int n = 0; n < N_IO; n++) begin
      entry_sel[n] = (entry_off == reg_addr_t'(n));
    end
    gpio_out_sel = (reg_req_i.addr == GPIO_OUT_ADDR);
    gpio_oe_sel  = (reg_req_i.addr == GPIO_OE_ADDR);
    gpio_in_sel  = (reg_req_i.addr == GPIO_IN_ADDR);
  end

  // pad entry table
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      for (int n = 0; n < N_IO; n++) begin
        entry_q[n] <= EntryRst;
      end
    end else if (reg_req_i.we) begin
      for (int n = 0; n < N_IO; n++) begin
        // only the low byte of the data word is kept
        if (entry_sel[n]) begin
          entry_q[n] <= pad_entry_t'(reg_req_i.wdata[EntryW-1:0]);
        end
      end
    end
  end

  // gpio output and direction
  // writes to the input address fall through here untouched
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
    end else if (reg_req_i.we) begin
      if (gpio_out_sel) begin
        gpio_out_q <= reg_req_i.wdata[N_IO-1:0];
      end
      if (gpio_oe_sel) begin
        gpio_oe_q <= reg_req_i.wdata[N_IO-1:0];
      end
    end
  end

  // readback mux, unmapped addresses and unused pads give zero
  always_comb begin
    rdata_d = '0;
    for (int n = 0; n < N_IO; n++) begin
      if (entry_sel[n]) begin
        rdata_d[EntryW-1:0] = entry_q[n];
      end
    end
    if (gpio_out_sel) begin
      rdata_d[N_IO-1:0] = gpio_out_q;
    end
    if (gpio_oe_sel) begin
      rdata_d[N_IO-1:0] = gpio_oe_q;
    end
    if (gpio_in_sel) begin
      rdata_d[N_IO-1:0] = gpio_in_i;
    end
  end

  // sampled every cycle, so a read sees the state before a same-cycle write
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      reg_rdata_o <= '0;
    end else begin
      reg_rdata_o <= rdata_d;
    end
  end

  assign pad_entry_o = entry_q;
  assign gpio_out_o  = gpio_out_q;
  assign gpio_oe_o   = gpio_oe_q;

endmodule

`default_nettype wire

/* design/io_subsystem.sv */
// top of the io subsystem, register block steering the pad multiplexer
`timescale 1ns/1ps
`default_nettype none

module io_subsystem #(
  parameter int unsigned N_IO = 16
) (
  input  wire                                ref_clk_i,
  input  wire                                rst_i,
  // register access
  input  io_pkg::reg_req_t                   reg_req_i,
  output io_pkg::reg_data_t                  reg_rdata_o,
  // peripheral io bus
  input  wire                [N_IO-1:0]      perio_out_i,
  input  wire                [N_IO-1:0]      perio_oe_i,
  output logic               [N_IO-1:0]      perio_in_o,
  // efpga io bus
  input  wire                [N_IO-1:0]      fpgaio_out_i,
  input  wire                [N_IO-1:0]      fpgaio_oe_i,
  output logic               [N_IO-1:0]      fpgaio_in_o,
  // pad side, split into in/out/oe
  input  wire                [N_IO-1:0]      io_in_i,
  output logic               [N_IO-1:0]      io_out_o,
  output logic               [N_IO-1:0]      io_oe_o,
  output io_pkg::pad_cfg_t   [N_IO-1:0]      pad_cfg_o
);

  import io_pkg::*;

  // register block to multiplexer
  pad_entry_t [N_IO-1:0] s_pad_entry;
  logic       [N_IO-1:0] s_gpio_out;
  logic       [N_IO-1:0] s_gpio_oe;
  // synchronized inputs back into the gpio register
  logic       [N_IO-1:0] s_gpio_in;

  io_regs #(
    .N_IO(N_IO)
  ) i_io_regs (
    .ref_clk_i  (ref_clk_i),
    .rst_i      (rst_i),
    .reg_req_i  (reg_req_i),
    .reg_rdata_o(reg_rdata_o),
    .pad_entry_o(s_pad_entry),
    .gpio_out_o (s_gpio_out),
    .gpio_oe_o  (s_gpio_oe),
    .gpio_in_i  (s_gpio_in)
  );

  pad_mux #(
    .N_IO(N_IO)
  ) i_pad_mux (
    .ref_clk_i   (ref_clk_i),
    .rst_i       (rst_i),
    .pad_entry_i (s_pad_entry),
    .gpio_out_i  (s_gpio_out),
    .gpio_oe_i   (s_gpio_oe),
    .perio_out_i (perio_out_i),
    .perio_oe_i  (perio_oe_i),
    .fpgaio_out_i(fpgaio_out_i),
    .fpgaio_oe_i (fpgaio_oe_i),
    .io_in_i     (io_in_i),
    .io_out_o    (io_out_o),
    .io_oe_o     (io_oe_o),
    .pad_cfg_o   (pad_cfg_o),
    .perio_in_o  (perio_in_o),
    .fpgaio_in_o (fpgaio_in_o),
    .gpio_in_o   (s_gpio_in)
  );

endmodule

`default_nettype wire

/* design/pad_mux.sv */
// per-pad selection of out/oe from the owning source, plus input sync and routing back
`timescale 1ns/1ps
`default_nettype none

module pad_mux #(
  parameter int unsigned N_IO = 16
) (
  input  wire                                ref_clk_i,
  input  wire                                rst_i,
  // pad table from the register block
  input  io_pkg::pad_entry_t [N_IO-1:0]      pad_entry_i,
  // source side outputs
  input  wire                [N_IO-1:0]      gpio_out_i,
  input  wire                [N_IO-1:0]      gpio_oe_i,
  input  wire                [N_IO-1:0]      perio_out_i,
  input  wire                [N_IO-1:0]      perio_oe_i,
  input  wire                [N_IO-1:0]      fpgaio_out_i,
  input  wire                [N_IO-1:0]      fpgaio_oe_i,
  // pad side
  input  wire                [N_IO-1:0]      io_in_i,
  output logic               [N_IO-1:0]      io_out_o,
  output logic               [N_IO-1:0]      io_oe_o,
  output io_pkg::pad_cfg_t   [N_IO-1:0]      pad_cfg_o,
  // synchronized inputs back to the sources
  output logic               [N_IO-1:0]      perio_in_o,
  output logic               [N_IO-1:0]      fpgaio_in_o,
  output logic               [N_IO-1:0]      gpio_in_o
);

  import io_pkg::*;

  // one-hot owner per pad, all zero for a parked pad
  logic [N_IO-1:0] own_gpio;
  logic [N_IO-1:0] own_perio;
  logic [N_IO-1:0] own_fpgaio;

  // two stage synchronizer
  logic [N_IO-1:0] io_in_meta;
  logic [N_IO-1:0] io_in_sync;

  always_comb begin
    for (int n = 0; n < N_IO; n++) begin
      own_gpio[n]   = 1'b0;
      own_perio[n]  = 1'b0;
      own_fpgaio[n] = 1'b0;
      case (pad_entry_i[n].src)
        PAD_SRC_GPIO:   own_gpio[n]   = 1'b1;
        PAD_SRC_PERIO:  own_perio[n]  = 1'b1;
        PAD_SRC_FPGAIO: own_fpgaio[n] = 1'b1;
        default:        ;
      endcase
      // cfg goes to the pad cell whoever owns it
      pad_cfg_o[n] = pad_entry_i[n].cfg;
    end
  end

  // output path is purely combinational
  assign io_out_o = (gpio_out_i   & own_gpio)
                  | (perio_out_i  & own_perio)
                  | (fpgaio_out_i & own_fpgaio);

  // parked pads end up with oe low and so stay tristated
  assign io_oe_o  = (gpio_oe_i    & own_gpio)
                  | (perio_oe_i   & own_perio)
                  | (fpgaio_oe_i  & own_fpgaio);

  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      io_in_meta <= '0;
      io_in_sync <= '0;
    end else begin
      io_in_meta <= io_in_i;
      io_in_sync <= io_in_meta;
    end
  end

  // peripheral and fpga only see pads they own
  assign perio_in_o  = io_in_sync & own_perio;
  assign fpgaio_in_o = io_in_sync & own_fpgaio;

  // gpio input register reads every pad regardless of owner
  assign gpio_in_o   = io_in_sync;

endmodule

`default_nettype wire

/* io_subsystem.f */
design/io_pkg.sv
design/io_regs.sv
design/pad_mux.sv
design/io_subsystem.sv
tb/tb_io_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# build the io subsystem testbench with verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_io_subsystem \
  -f io_subsystem.f

./obj_dir/Vtb_io_subsystem | tee "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

echo "simulation passed"

/* tb/tb_io_subsystem.sv */
// self-checking testbench for io_subsystem, compiled together with the rtl through the file list
`timescale 1ns/1ps
`default_nettype none

module tb_io_subsystem;

  import io_pkg::*;

  localparam int unsigned N_IO = 16;
  // watchdog limit for the whole run, in clock cycles
  localparam int unsigned TIMEOUT_CYCLES = 10000;

  logic                ref_clk;
  logic                rst;
  reg_req_t            reg_req;
  reg_data_t           reg_rdata;
  logic     [N_IO-1:0] perio_out;
  logic     [N_IO-1:0] perio_oe;
  logic     [N_IO-1:0] perio_in;
  logic     [N_IO-1:0] fpgaio_out;
  logic     [N_IO-1:0] fpgaio_oe;
  logic     [N_IO-1:0] fpgaio_in;
  logic     [N_IO-1:0] io_in;
  logic     [N_IO-1:0] io_out;
  logic     [N_IO-1:0] io_oe;
  pad_cfg_t [N_IO-1:0] pad_cfg;

  // shadow of the register state as seen by the pads
  pad_entry_t          shadow_entry [N_IO];
  logic     [N_IO-1:0] shadow_gpio_out;
  logic     [N_IO-1:0] shadow_gpio_oe;

  logic                out_chk_en;
  // low while the input synchronizer is still catching up with io_in
  logic                route_chk_en;
  logic                rd_req_valid;
  reg_addr_t           rd_req_addr;
  reg_data_t           rd_req_word;
  logic                rd_chk_valid = 1'b0;
  reg_addr_t           rd_chk_addr;
  reg_data_t           rd_chk_word;

  int unsigned reset_errs = 0;
  int unsigned out_errs   = 0;
  int unsigned route_errs = 0;
  int unsigned read_errs  = 0;

  io_subsystem #(
    .N_IO(N_IO)
  ) i_io_subsystem (
    .ref_clk_i   (ref_clk),
    .rst_i       (rst),
    .reg_req_i   (reg_req),
    .reg_rdata_o (reg_rdata),
    .perio_out_i (perio_out),
    .perio_oe_i  (perio_oe),
    .perio_in_o  (perio_in),
    .fpgaio_out_i(fpgaio_out),
    .fpgaio_oe_i (fpgaio_oe),
    .fpgaio_in_o (fpgaio_in),
    .io_in_i     (io_in),
    .io_out_o    (io_out),
    .io_oe_o     (io_oe),
    .pad_cfg_o   (pad_cfg)
  );

  initial begin
    ref_clk = 1'b0;
    forever #2 ref_clk = ~ref_clk;
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge ref_clk);
    $display("timeout: the stimulus did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

  function automatic logic [N_IO-1:0] rand_bits();
    logic [31:0] r;
    r = $urandom();
    return r[N_IO-1:0];
  endfunction

  // expected {oe, out} of one pad from its owner
  function automatic logic [1:0] expect_pad(int n);
    case (shadow_entry[n].src)
      PAD_SRC_GPIO:   return {shadow_gpio_oe[n], shadow_gpio_out[n]};
      PAD_SRC_PERIO:  return {perio_oe[n], perio_out[n]};
      PAD_SRC_FPGAIO: return {fpgaio_oe[n], fpgaio_out[n]};
      default:        return 2'b00;
    endcase
  endfunction

  // a source only sees the settled inputs of pads it owns
  function automatic logic [N_IO-1:0] expect_route(pad_src_e owner);
    logic [N_IO-1:0] r;
    for (int n = 0; n < N_IO; n++) begin
      r[n] = (shadow_entry[n].src == owner) ? io_in[n] : 1'b0;
    end
    return r;
  endfunction

  // GPIO_IN assumes io_in has been steady long enough to pass the synchronizer
  function automatic reg_data_t expect_read(reg_addr_t addr);
    int off;
    off = int'(addr) - int'(PAD_ENTRY_BASE);
    if (off >= 0 && off < int'(N_IO)) begin
      return {24'h0, shadow_entry[off]};
    end else if (addr == GPIO_OUT_ADDR) begin
      return {{(32-N_IO){1'b0}}, shadow_gpio_out};
    end else if (addr == GPIO_OE_ADDR) begin
      return {{(32-N_IO){1'b0}}, shadow_gpio_oe};
    end else if (addr == GPIO_IN_ADDR) begin
      return {{(32-N_IO){1'b0}}, io_in};
    end
    return '0;
  endfunction

  function automatic void shadow_write(reg_addr_t addr, reg_data_t data);
    int off;
    off = int'(addr) - int'(PAD_ENTRY_BASE);
    if (off >= 0 && off < int'(N_IO)) begin
      shadow_entry[off] = pad_entry_t'(data[7:0]);
    end else if (addr == GPIO_OUT_ADDR) begin
      shadow_gpio_out = data[N_IO-1:0];
    end else if (addr == GPIO_OE_ADDR) begin
      shadow_gpio_oe = data[N_IO-1:0];
    end
  endfunction

  task automatic wait_cycles(int unsigned count);
    for (int unsigned i = 0; i < count; i++) begin
      @(posedge ref_clk);
    end
  endtask

  // shadow follows on the edge where the dut takes the write
  task automatic bus_write(reg_addr_t addr, reg_data_t data);
    @(posedge ref_clk);
    reg_req <= '{we: 1'b1, addr: addr, wdata: data};
    @(posedge ref_clk);
    reg_req <= '0;
    shadow_write(addr, data);
  endtask

  task automatic bus_read(reg_addr_t addr);
    @(posedge ref_clk);
    reg_req      <= '{we: 1'b0, addr: addr, wdata: '0};
    rd_req_valid <= 1'b1;
    rd_req_addr  <= addr;
    rd_req_word  <= expect_read(addr);
    @(posedge ref_clk);
    reg_req      <= '0;
    rd_req_valid <= 1'b0;
  endtask

  task automatic read_all_addresses();
    for (int a = 0; a < 256; a++) begin
      bus_read(reg_addr_t'(a));
    end
  endtask

  // full 32-bit data so the byte and N_IO masks get exercised
  task automatic randomize_registers();
    for (int n = 0; n < N_IO; n++) begin
      bus_write(reg_addr_t'(int'(PAD_ENTRY_BASE) + n), $urandom());
    end
    bus_write(GPIO_OUT_ADDR, $urandom());
    bus_write(GPIO_OE_ADDR, $urandom());
  endtask

  task automatic read_registers();
    for (int n = 0; n < N_IO; n++) begin
      bus_read(reg_addr_t'(int'(PAD_ENTRY_BASE) + n));
    end
    bus_read(GPIO_OUT_ADDR);
    bus_read(GPIO_OE_ADDR);
  endtask

  task automatic drive_sources();
    @(posedge ref_clk);
    perio_out  <= rand_bits();
    perio_oe   <= rand_bits();
    fpgaio_out <= rand_bits();
    fpgaio_oe  <= rand_bits();
  endtask

  // two edges through the synchronizer, one more for margin
  task automatic settle_inputs();
    @(posedge ref_clk);
    io_in        <= rand_bits();
    route_chk_en <= 1'b0;
    wait_cycles(3);
    route_chk_en <= 1'b1;
  endtask

  task automatic check_idle_pads();
    @(negedge ref_clk);
    assert (io_out === '0 && io_oe === '0 && pad_cfg === '0) else begin
      reset_errs = reset_errs + 1;
      $display("Error at %0t: pads not idle after reset, out %h oe %h cfg %h",
               $time, io_out, io_oe, pad_cfg);
    end
  endtask

  // readback lands one edge after the address
  always @(posedge ref_clk) begin
    rd_chk_valid <= rd_req_valid;
    rd_chk_addr  <= rd_req_addr;
    rd_chk_word  <= rd_req_word;
  end

  always @(negedge ref_clk) begin : compare
    logic [1:0] exp_pad;
    if (out_chk_en) begin
      for (int n = 0; n < N_IO; n++) begin
        exp_pad = expect_pad(n);
        assert (io_out[n] === exp_pad[0] && io_oe[n] === exp_pad[1]) else begin
          out_errs = out_errs + 1;
          $display("Error at %0t: pad %0d out %b oe %b, expected out %b oe %b",
                   $time, n, io_out[n], io_oe[n], exp_pad[0], exp_pad[1]);
        end
        assert (pad_cfg[n] === shadow_entry[n].cfg) else begin
          out_errs = out_errs + 1;
          $display("Error at %0t: pad %0d cfg %h, expected %h",
                   $time, n, pad_cfg[n], shadow_entry[n].cfg);
        end
      end
    end
    if (route_chk_en) begin
      assert (perio_in === expect_route(PAD_SRC_PERIO)) else begin
        route_errs = route_errs + 1;
        $display("Error at %0t: perio_in %h, expected %h",
                 $time, perio_in, expect_route(PAD_SRC_PERIO));
      end
      assert (fpgaio_in === expect_route(PAD_SRC_FPGAIO)) else begin
        route_errs = route_errs + 1;
        $display("Error at %0t: fpgaio_in %h, expected %h",
                 $time, fpgaio_in, expect_route(PAD_SRC_FPGAIO));
      end
    end
    if (rd_chk_valid) begin
      assert (reg_rdata === rd_chk_word) else begin
        read_errs = read_errs + 1;
        $display("Error at %0t: read of %h returned %h, expected %h",
                 $time, rd_chk_addr, reg_rdata, rd_chk_word);
      end
    end
  end

  initial begin : stimulus
    void'($urandom(32'h5aa));
    rst          = 1'b1;
    reg_req      = '0;
    perio_out    = '0;
    perio_oe     = '0;
    fpgaio_out   = '0;
    fpgaio_oe    = '0;
    io_in        = '0;
    out_chk_en   = 1'b0;
    route_chk_en = 1'b0;
    rd_req_valid = 1'b0;
    rd_req_addr  = '0;
    rd_req_word  = '0;
    for (int n = 0; n < N_IO; n++) begin
      shadow_entry[n] = '{cfg: '0, src: PAD_SRC_OFF};
    end
    shadow_gpio_out = '0;
    shadow_gpio_oe  = '0;

    wait_cycles(2);
    rst          <= 1'b0;
    out_chk_en   <= 1'b1;
    route_chk_en <= 1'b1;

    // reset state, every address reads zero
    check_idle_pads();
    read_all_addresses();

    // random writes and readback
    repeat (4) begin
      randomize_registers();
      read_registers();
    end

    // output selection under random owners and source values
    repeat (10) begin
      randomize_registers();
      repeat (20) drive_sources();
    end

    // input routing
    repeat (8) begin
      settle_inputs();
      randomize_registers();
      bus_read(GPIO_IN_ADDR);
    end

    // writes that must be ignored
    bus_write(GPIO_IN_ADDR, $urandom());
    for (int n = N_IO; n < int'(IO_MAX_PADS); n++) begin
      bus_write(reg_addr_t'(int'(PAD_ENTRY_BASE) + n), $urandom());
    end
    repeat (20) begin
      bus_write(reg_addr_t'($urandom_range(255, 35)), $urandom());
    end
    read_all_addresses();
    wait_cycles(2);

    $display("error counts: reset %0d, outputs %0d, routing %0d, readback %0d",
             reset_errs, out_errs, route_errs, read_errs);
    if (reset_errs + out_errs + route_errs + read_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
